//--- filelist.f
+incdir+test
logic/scancode_pkg.sv
logic/cab_pkg.sv
logic/kbd_decoder.sv
logic/rotary_clock.sv
logic/player_input.sv
logic/cab_encoder.sv
logic/cab_inputs_top.sv
test/tb_cab_inputs.sv

//--- logic/cab_encoder.sv
// Core input port encoder
`timescale 1ns/1ps

module cab_encoder (
	input  logic                                                CLK_49M,
	input  logic                                                rst,
	input  logic [cab_pkg::NUM_PLAYERS-1:0][cab_pkg::DIR_W-1:0] p_dir,
	input  logic [cab_pkg::NUM_PLAYERS-1:0][cab_pkg::BTN_W-1:0] p_btn,
	input  logic [cab_pkg::NUM_PLAYERS-1:0]                     p_start,
	input  logic [cab_pkg::NUM_PLAYERS-1:0]                     p_coin_req,
	input  logic [cab_pkg::NUM_PLAYERS-1:0][cab_pkg::ROT_W-1:0] p_rotary,
	input  logic [1:0]                                          key_coin,
	input  logic                                                key_service,
	input  logic [1:0]                                          is_bootleg,
	output logic [1:0]                                          core_coins,
	output logic                                                core_service,
	output logic [cab_pkg::NUM_PLAYERS-1:0]                     core_start,
	output logic [cab_pkg::NUM_PLAYERS-1:0][cab_pkg::DIR_W-1:0] core_joystick,
	output logic [cab_pkg::NUM_PLAYERS-1:0][cab_pkg::BTN_W-1:0] core_buttons,
	output logic [cab_pkg::NUM_PLAYERS-1:0][cab_pkg::ROT_W-1:0] core_rotary
);

	logic                                                bootleg;
	logic [1:0]                                          coins;    // coin2, coin1
	logic [cab_pkg::NUM_PLAYERS-1:0][cab_pkg::ROT_W-1:0] rot_src;
	logic [cab_pkg::ROT_W-1:0]                           rot_rst;  // Rotary value held in reset

	assign bootleg = (is_bootleg == cab_pkg::BOOTLEG_CODE);
	assign coins   = {key_coin[1], key_coin[0] | (|p_coin_req)}; // Pad coin only on coin1

	// No rotary on bootleg PCBs, park both at idle
	assign rot_src = bootleg ? {cab_pkg::NUM_PLAYERS{cab_pkg::ROT_IDLE}} : p_rotary;
	assign rot_rst = bootleg ? cab_pkg::ROT_IDLE : cab_pkg::ROT_HOME;

	// ====================
	// Active-low output registers
	always_ff @(posedge CLK_49M) begin
		if (rst) begin
			core_coins    <= '1; // All inactive
			core_service  <= 1'b1;
			core_start    <= '1;
			core_joystick <= '1;
			core_buttons  <= '1;
			core_rotary   <= {cab_pkg::NUM_PLAYERS{~rot_rst}};
		end else begin
			core_coins    <= ~coins;
			core_service  <= ~key_service;
			core_start    <= ~p_start;
			core_joystick <= ~p_dir;
			core_buttons  <= ~p_btn;
			core_rotary   <= ~rot_src;
		end
	end

endmodule

//--- logic/cab_inputs_top.sv
// Player input front end
`timescale 1ns/1ps

module cab_inputs_top #(
	parameter int ROT_DIV_BITS = 23
) (
	input  logic                                                CLK_49M,
	input  logic                                                rst,
	input  logic [10:0]                                         ps2_key,
	input  logic [cab_pkg::JOY_W-1:0]                           joy0,
	input  logic [cab_pkg::JOY_W-1:0]                           joy1,
	input  logic                                                rot_fast,
	input  logic [1:0]                                          is_bootleg,
	output logic [1:0]                                          core_coins,
	output logic                                                core_service,
	output logic [cab_pkg::NUM_PLAYERS-1:0]                     core_start,
	output logic [cab_pkg::NUM_PLAYERS-1:0][cab_pkg::DIR_W-1:0] core_joystick,
	output logic [cab_pkg::NUM_PLAYERS-1:0][cab_pkg::BTN_W-1:0] core_buttons,
	output logic [cab_pkg::NUM_PLAYERS-1:0][cab_pkg::ROT_W-1:0] core_rotary
);

	logic [17:0]                                         keys;
	logic                                                rot_tick;
	logic [cab_pkg::NUM_PLAYERS-1:0][cab_pkg::JOY_W-1:0] joy_all;
	logic [cab_pkg::NUM_PLAYERS-1:0][cab_pkg::DIR_W-1:0] p_dir;
	logic [cab_pkg::NUM_PLAYERS-1:0][cab_pkg::BTN_W-1:0] p_btn;
	logic [cab_pkg::NUM_PLAYERS-1:0]                     p_start;
	logic [cab_pkg::NUM_PLAYERS-1:0]                     p_coin_req;
	logic [cab_pkg::NUM_PLAYERS-1:0][cab_pkg::ROT_W-1:0] p_rotary;

	assign joy_all = {joy1, joy0};

	kbd_decoder u_kbd (
		.CLK_49M (CLK_49M),
		.rst     (rst),
		.ps2_key (ps2_key),
		.keys    (keys)
	);

	rotary_clock #(
		.ROT_DIV_BITS (ROT_DIV_BITS)
	) u_rot_clk (
		.CLK_49M  (CLK_49M),
		.rst      (rst),
		.rot_fast (rot_fast),
		.rot_tick (rot_tick) // Shared by both players
	);

	// ====================
	// One block per player, key group picked by stride
	for (genvar p = 0; p < cab_pkg::NUM_PLAYERS; p++) begin : g_player
		localparam int BASE = scancode_pkg::KEY_P1_RIGHT + p * scancode_pkg::KEY_GRP;

		player_input u_player (
			.CLK_49M   (CLK_49M),
			.rst       (rst),
			.key_dir   (keys[BASE +: cab_pkg::DIR_W]),                   // up..right
			.key_btn   (keys[BASE + cab_pkg::DIR_W +: cab_pkg::BTN_W]), // missile, shot
			.key_start (keys[scancode_pkg::KEY_START1 + p]),
			.joy       (joy_all[p]),
			.rot_tick  (rot_tick),
			.dir       (p_dir[p]),
			.btn       (p_btn[p]),
			.start     (p_start[p]),
			.coin_req  (p_coin_req[p]),
			.rotary    (p_rotary[p])
		);
	end

	cab_encoder u_enc (
		.CLK_49M       (CLK_49M),
		.rst           (rst),
		.p_dir         (p_dir),
		.p_btn         (p_btn),
		.p_start       (p_start),
		.p_coin_req    (p_coin_req),
		.p_rotary      (p_rotary),
		.key_coin      ({keys[scancode_pkg::KEY_COIN2], keys[scancode_pkg::KEY_COIN1]}),
		.key_service   (keys[scancode_pkg::KEY_SERVICE]),
		.is_bootleg    (is_bootleg),
		.core_coins    (core_coins),
		.core_service  (core_service),
		.core_start    (core_start),
		.core_joystick (core_joystick),
		.core_buttons  (core_buttons),
		.core_rotary   (core_rotary)
	);

endmodule

//--- logic/cab_pkg.sv
// Cabinet port constants
package cab_pkg;

	// ====================
	// Player count and word widths
	localparam int NUM_PLAYERS = 2;
	localparam int JOY_W       = 16; // Gamepad word
	localparam int DIR_W       = 4;  // down, up, right, left
	localparam int BTN_W       = 2;  // missile, shot

	// ====================
	// Rotary joystick, one-hot position
	localparam int ROT_W = 8;

	localparam logic [ROT_W-1:0] ROT_HOME = 8'h01; // Reset position
	localparam logic [ROT_W-1:0] ROT_TOP  = 8'h80; // Last position before wrap
	localparam logic [ROT_W-1:0] ROT_IDLE = 8'hFF; // No rotary fitted

	// Board flag value for bootleg PCBs
	// These boards have no rotary hardware
	localparam logic [1:0] BOOTLEG_CODE = 2'b01;

endpackage

//--- logic/kbd_decoder.sv
// PS/2 key state decoder
`timescale 1ns/1ps

module kbd_decoder (
	input  logic        CLK_49M,
	input  logic        rst,
	input  logic [10:0] ps2_key,
	output logic [17:0] keys
);

	logic       old_tgl;  // Toggle bit one cycle back
	logic       new_evt;
	logic       pressed;
	logic [7:0] code;

	assign new_evt = (old_tgl != ps2_key[scancode_pkg::PS2_TOGGLE]);
	assign pressed = ps2_key[scancode_pkg::PS2_PRESSED];
	assign code    = ps2_key[7:0];

	always_ff @(posedge CLK_49M) begin
		old_tgl <= ps2_key[scancode_pkg::PS2_TOGGLE];
	end

	// ====================
	// Held key registers
	always_ff @(posedge CLK_49M) begin
		if (rst) begin
			keys <= '0;
		end else if (new_evt) begin
			case (code)
				scancode_pkg::SC_START1:     keys[scancode_pkg::KEY_START1]     <= pressed;
				scancode_pkg::SC_START2:     keys[scancode_pkg::KEY_START2]     <= pressed;
				scancode_pkg::SC_COIN1:      keys[scancode_pkg::KEY_COIN1]      <= pressed;
				scancode_pkg::SC_COIN2:      keys[scancode_pkg::KEY_COIN2]      <= pressed;
				scancode_pkg::SC_SERVICE:    keys[scancode_pkg::KEY_SERVICE]    <= pressed;

				scancode_pkg::SC_P1_UP:      keys[scancode_pkg::KEY_P1_UP]      <= pressed;
				scancode_pkg::SC_P1_DOWN:    keys[scancode_pkg::KEY_P1_DOWN]    <= pressed;
				scancode_pkg::SC_P1_LEFT:    keys[scancode_pkg::KEY_P1_LEFT]    <= pressed;
				scancode_pkg::SC_P1_RIGHT:   keys[scancode_pkg::KEY_P1_RIGHT]   <= pressed;
				scancode_pkg::SC_P1_SHOT:    keys[scancode_pkg::KEY_P1_SHOT]    <= pressed;
				scancode_pkg::SC_P1_MISSILE: keys[scancode_pkg::KEY_P1_MISSILE] <= pressed;

				scancode_pkg::SC_P2_UP:      keys[scancode_pkg::KEY_P2_UP]      <= pressed;
				scancode_pkg::SC_P2_DOWN:    keys[scancode_pkg::KEY_P2_DOWN]    <= pressed;
				scancode_pkg::SC_P2_LEFT:    keys[scancode_pkg::KEY_P2_LEFT]    <= pressed;
				scancode_pkg::SC_P2_RIGHT:   keys[scancode_pkg::KEY_P2_RIGHT]   <= pressed;
				scancode_pkg::SC_P2_SHOT:    keys[scancode_pkg::KEY_P2_SHOT]    <= pressed;
				scancode_pkg::SC_P2_MISSILE: keys[scancode_pkg::KEY_P2_MISSILE] <= pressed;
				default: ; // Unknown codes leave key states alone
			endcase
		end
	end

	// Keys come out of reset all released
	a_keys_clear: assert property (@(posedge CLK_49M)
		rst |=> (keys == '0));

endmodule

//--- logic/player_input.sv
// Per-player control merge
`timescale 1ns/1ps

module player_input (
	input  logic                       CLK_49M,
	input  logic                       rst,
	input  logic [cab_pkg::DIR_W-1:0]  key_dir,   // up, down, left, right
	input  logic [cab_pkg::BTN_W-1:0]  key_btn,   // missile, shot
	input  logic                       key_start,
	input  logic [cab_pkg::JOY_W-1:0]  joy,
	input  logic                       rot_tick,
	output logic [cab_pkg::DIR_W-1:0]  dir,       // down, up, right, left
	output logic [cab_pkg::BTN_W-1:0]  btn,       // missile, shot
	output logic                       start,
	output logic                       coin_req,
	output logic [cab_pkg::ROT_W-1:0]  rotary
);

	logic rot_l;
	logic rot_r;

	// ====================
	// Keyboard OR gamepad
	assign dir[3] = key_dir[2] | joy[scancode_pkg::JOY_DOWN];
	assign dir[2] = key_dir[3] | joy[scancode_pkg::JOY_UP];
	assign dir[1] = key_dir[0] | joy[scancode_pkg::JOY_RIGHT];
	assign dir[0] = key_dir[1] | joy[scancode_pkg::JOY_LEFT];

	assign btn[1] = key_btn[1] | joy[scancode_pkg::JOY_MISSILE];
	assign btn[0] = key_btn[0] | joy[scancode_pkg::JOY_SHOT];

	assign start    = key_start | joy[scancode_pkg::JOY_START];
	assign coin_req = joy[scancode_pkg::JOY_COIN]; // Merged with key coin in encoder

	// Rotary buttons only exist on the gamepad
	assign rot_l = joy[scancode_pkg::JOY_ROT_L];
	assign rot_r = joy[scancode_pkg::JOY_ROT_R];

	// ====================
	// Rotary position, one-hot ring
	always_ff @(posedge CLK_49M) begin
		if (rst) begin
			rotary <= cab_pkg::ROT_HOME;
		end else if (rot_tick) begin
			if (rot_l) begin // Left wins over right
				if (rotary == cab_pkg::ROT_TOP)
					rotary <= cab_pkg::ROT_HOME;
				else
					rotary <= rotary << 1;
			end else if (rot_r) begin
				if (rotary == cab_pkg::ROT_HOME)
					rotary <= cab_pkg::ROT_TOP;
				else
					rotary <= rotary >> 1;
			end
		end
	end

	// Wrap logic must never lose or duplicate the hot bit
	a_rot_onehot: assert property (@(posedge CLK_49M) disable iff (rst)
		$onehot(rotary));

endmodule

//--- logic/rotary_clock.sv
// Rotary step tick divider
`timescale 1ns/1ps

module rotary_clock #(
	parameter int ROT_DIV_BITS = 23
) (
	input  logic CLK_49M,
	input  logic rst,
	input  logic rot_fast,
	output logic rot_tick
);

	logic [ROT_DIV_BITS-1:0] div_cnt; // Free-running
	logic                    wrap_slow;
	logic                    wrap_fast;

	assign wrap_slow = (div_cnt == '0);
	assign wrap_fast = (div_cnt[ROT_DIV_BITS-2:0] == '0); // Top bit ignored, half period

	always_ff @(posedge CLK_49M) begin
		if (rst) begin
			div_cnt  <= '0;
			rot_tick <= 1'b0;
		end else begin
			div_cnt  <= div_cnt + 1'b1;
			rot_tick <= rot_fast ? wrap_fast : wrap_slow; // One cycle strobe
		end
	end

	// Tick is a strobe, even in fast mode
	a_tick_single: assert property (@(posedge CLK_49M) disable iff (rst)
		rot_tick |=> !rot_tick);

endmodule

//--- logic/scancode_pkg.sv
// Keyboard and gamepad codes
package scancode_pkg;

	// ====================
	// PS/2 scancodes, set 2 make codes
	localparam logic [7:0] SC_START1     = 8'h16; // 1
	localparam logic [7:0] SC_START2     = 8'h1E; // 2
	localparam logic [7:0] SC_COIN1      = 8'h2E; // 5
	localparam logic [7:0] SC_COIN2      = 8'h36; // 6
	localparam logic [7:0] SC_SERVICE    = 8'h46; // 9
	localparam logic [7:0] SC_P1_UP      = 8'h75; // Cursor keys
	localparam logic [7:0] SC_P1_DOWN    = 8'h72;
	localparam logic [7:0] SC_P1_LEFT    = 8'h6B;
	localparam logic [7:0] SC_P1_RIGHT   = 8'h74;
	localparam logic [7:0] SC_P1_SHOT    = 8'h14; // Ctrl
	localparam logic [7:0] SC_P1_MISSILE = 8'h11; // Alt
	localparam logic [7:0] SC_P2_UP      = 8'h1D; // W
	localparam logic [7:0] SC_P2_DOWN    = 8'h1B; // S
	localparam logic [7:0] SC_P2_LEFT    = 8'h1C; // A
	localparam logic [7:0] SC_P2_RIGHT   = 8'h23; // D
	localparam logic [7:0] SC_P2_SHOT    = 8'h2A; // V
	localparam logic [7:0] SC_P2_MISSILE = 8'h32; // B

	// ====================
	// Held-key vector layout, player groups are right/left/down/up/shot/missile
	localparam int NUM_KEYS       = 18;
	localparam int KEY_GRP        = 6;  // Stride between player groups
	localparam int KEY_P1_RIGHT   = 0;
	localparam int KEY_P1_LEFT    = 1;
	localparam int KEY_P1_DOWN    = 2;
	localparam int KEY_P1_UP      = 3;
	localparam int KEY_P1_SHOT    = 4;
	localparam int KEY_P1_MISSILE = 5;
	localparam int KEY_P2_RIGHT   = KEY_P1_RIGHT + KEY_GRP;
	localparam int KEY_P2_LEFT    = KEY_P1_LEFT + KEY_GRP;
	localparam int KEY_P2_DOWN    = KEY_P1_DOWN + KEY_GRP;
	localparam int KEY_P2_UP      = KEY_P1_UP + KEY_GRP;
	localparam int KEY_P2_SHOT    = KEY_P1_SHOT + KEY_GRP;
	localparam int KEY_P2_MISSILE = KEY_P1_MISSILE + KEY_GRP;
	localparam int KEY_START1     = 12;
	localparam int KEY_START2     = 13;
	localparam int KEY_COIN1      = 14;
	localparam int KEY_COIN2      = 15;
	localparam int KEY_SERVICE    = 16;
	localparam int KEY_RSVD       = 17; // Spare slot, never written

	// ====================
	// Gamepad word bits
	localparam int JOY_RIGHT   = 0;
	localparam int JOY_LEFT    = 1;
	localparam int JOY_DOWN    = 2;
	localparam int JOY_UP      = 3;
	localparam int JOY_SHOT    = 4;
	localparam int JOY_MISSILE = 5;
	localparam int JOY_ROT_R   = 6;
	localparam int JOY_ROT_L   = 7;
	localparam int JOY_START   = 8;
	localparam int JOY_COIN    = 9;

	// PS/2 event word fields
	localparam int PS2_TOGGLE  = 10;
	localparam int PS2_PRESSED = 9;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# Builds and runs the cabinet input testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f filelist.f --top-module tb_cab_inputs -Mdir obj_dir -o sim_cab_inputs
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/sim_cab_inputs > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
	echo "Simulation FAILED"
	exit 1
fi
echo "Simulation PASSED"
exit 0

//--- test/tb_tasks.svh
// Testbench stimulus and wait tasks

// ====================
// Keyboard events, one toggle flip each
task automatic send_key(input logic [7:0] code, input logic pressed);
	@(negedge CLK_49M);
	ps2_key = {~ps2_key[scancode_pkg::PS2_TOGGLE], pressed, 1'b0, code};
	for (int i = 0; i < NUM_CODES; i++) begin
		if (sc_list[i] == code)
			mkeys[key_idx[i]] = pressed; // Unknown codes leave the model alone
	end
endtask

task automatic idle(input int n);
	repeat (n) @(negedge CLK_49M);
endtask

// Reset for 3 rising edges, model keys cleared with it
task automatic apply_reset();
	@(negedge CLK_49M);
	rst   = 1'b1;
	mkeys = '0;
	repeat (3) @(posedge CLK_49M);
	@(negedge CLK_49M);
	rst = 1'b0;
endtask

// ====================
// Bounded wait for the next rotary step of one player
task automatic wait_rot_change(input int p, input int max_cycles, output int cycles);
	logic [7:0] prev;
	prev   = core_rotary[p];
	cycles = 0;
	while (core_rotary[p] == prev && cycles < max_cycles) begin
		@(negedge CLK_49M); // Ports settled here
		cycles++;
	end
	if (core_rotary[p] == prev) begin
		$display("Timeout: rotary of player %0d did not step within %0d cycles", p, max_cycles);
		errors++;
	end
endtask

//--- test/tb_cab_inputs.sv
// Cabinet input front end testbench
`timescale 1ns/1ps

module tb_cab_inputs;

	localparam int ROT_DIV_BITS = 6;
	localparam int DIV          = 1 << ROT_DIV_BITS; // Slow tick period
	localparam int NUM_CODES    = 17;

	logic            CLK_49M;
	logic            rst;
	logic [10:0]     ps2_key;
	logic [15:0]     joy0;
	logic [15:0]     joy1;
	logic            rot_fast;
	logic [1:0]      is_bootleg;
	logic [1:0]      core_coins;
	logic            core_service;
	logic [1:0]      core_start;
	logic [1:0][3:0] core_joystick;
	logic [1:0][1:0] core_buttons;
	logic [1:0][7:0] core_rotary;

	// ====================
	// Reference model
	logic [scancode_pkg::NUM_KEYS-1:0] mkeys;       // Held keys as sent
	logic [7:0]                        mrot [2];    // Expected rotary positions
	int                                tick_cnt;
	logic                              model_tick;
	int                                errors = 0;
	int                                err_mark;
	int                                tests_run = 0;
	int                                tests_failed = 0;
	string                             test_name;

	logic [7:0] sc_list [NUM_CODES] = '{
		scancode_pkg::SC_START1, scancode_pkg::SC_START2, scancode_pkg::SC_COIN1,
		scancode_pkg::SC_COIN2, scancode_pkg::SC_SERVICE, scancode_pkg::SC_P1_UP,
		scancode_pkg::SC_P1_DOWN, scancode_pkg::SC_P1_LEFT, scancode_pkg::SC_P1_RIGHT,
		scancode_pkg::SC_P1_SHOT, scancode_pkg::SC_P1_MISSILE, scancode_pkg::SC_P2_UP,
		scancode_pkg::SC_P2_DOWN, scancode_pkg::SC_P2_LEFT, scancode_pkg::SC_P2_RIGHT,
		scancode_pkg::SC_P2_SHOT, scancode_pkg::SC_P2_MISSILE};
	int key_idx [NUM_CODES] = '{
		scancode_pkg::KEY_START1, scancode_pkg::KEY_START2, scancode_pkg::KEY_COIN1,
		scancode_pkg::KEY_COIN2, scancode_pkg::KEY_SERVICE, scancode_pkg::KEY_P1_UP,
		scancode_pkg::KEY_P1_DOWN, scancode_pkg::KEY_P1_LEFT, scancode_pkg::KEY_P1_RIGHT,
		scancode_pkg::KEY_P1_SHOT, scancode_pkg::KEY_P1_MISSILE, scancode_pkg::KEY_P2_UP,
		scancode_pkg::KEY_P2_DOWN, scancode_pkg::KEY_P2_LEFT, scancode_pkg::KEY_P2_RIGHT,
		scancode_pkg::KEY_P2_SHOT, scancode_pkg::KEY_P2_MISSILE};

	`include "tb_tasks.svh"

	cab_inputs_top #(.ROT_DIV_BITS(ROT_DIV_BITS)) u_dut (
		.CLK_49M(CLK_49M), .rst(rst), .ps2_key(ps2_key), .joy0(joy0), .joy1(joy1),
		.rot_fast(rot_fast), .is_bootleg(is_bootleg), .core_coins(core_coins),
		.core_service(core_service), .core_start(core_start),
		.core_joystick(core_joystick), .core_buttons(core_buttons),
		.core_rotary(core_rotary)
	);

	initial begin
		CLK_49M = 1'b0;
		forever #5 CLK_49M = ~CLK_49M;
	end

	// Active low {down, up, right, left}
	function automatic logic [3:0] dir_expected(input logic [scancode_pkg::NUM_KEYS-1:0] k,
		input logic [15:0] j, input int p);
		int b;
		b = p * scancode_pkg::KEY_GRP;
		return ~{k[scancode_pkg::KEY_P1_DOWN + b] | j[scancode_pkg::JOY_DOWN],
			k[scancode_pkg::KEY_P1_UP + b] | j[scancode_pkg::JOY_UP],
			k[scancode_pkg::KEY_P1_RIGHT + b] | j[scancode_pkg::JOY_RIGHT],
			k[scancode_pkg::KEY_P1_LEFT + b] | j[scancode_pkg::JOY_LEFT]};
	endfunction

	// Active low {missile, shot}
	function automatic logic [1:0] btn_expected(input logic [scancode_pkg::NUM_KEYS-1:0] k,
		input logic [15:0] j, input int p);
		int b;
		b = p * scancode_pkg::KEY_GRP;
		return ~{k[scancode_pkg::KEY_P1_MISSILE + b] | j[scancode_pkg::JOY_MISSILE],
			k[scancode_pkg::KEY_P1_SHOT + b] | j[scancode_pkg::JOY_SHOT]};
	endfunction

	// Left rotates up and wins over right
	function automatic logic [7:0] rot_step(input logic [7:0] pos, input logic [15:0] j);
		if (j[scancode_pkg::JOY_ROT_L])
			return {pos[6:0], pos[7]};
		if (j[scancode_pkg::JOY_ROT_R])
			return {pos[0], pos[7:1]};
		return pos;
	endfunction

	// Bootleg boards read all zeros
	function automatic logic [7:0] rotary_expected(input logic [7:0] pos, input logic [1:0] boot);
		return (boot == 2'b01) ? 8'h00 : ~pos;
	endfunction

	// Tick every DIV cycles from reset release or every DIV/2 when fast
	always @(posedge CLK_49M) begin
		if (rst) begin
			tick_cnt   <= 0;
			model_tick <= 1'b0;
			mrot[0]    <= cab_pkg::ROT_HOME;
			mrot[1]    <= cab_pkg::ROT_HOME;
		end else begin
			tick_cnt   <= tick_cnt + 1;
			model_tick <= ((tick_cnt % DIV) == 0) || (rot_fast && ((tick_cnt % (DIV / 2)) == 0));
			if (model_tick) begin
				mrot[0] <= rot_step(mrot[0], joy0);
				mrot[1] <= rot_step(mrot[1], joy1);
			end
		end
	end

	task automatic log_mismatch(input string what);
		$display("** Error at time %0t: %s differs from the model", $time, what);
		errors++;
	endtask

	// ====================
	// Keys reach the ports 2 cycles late and gamepads 1
	a_joy0: assert property (@(posedge CLK_49M) disable iff (rst)
		core_joystick[0] == dir_expected($past(mkeys, 2), $past(joy0), 0))
		else log_mismatch("core_joystick[0]");
	a_joy1: assert property (@(posedge CLK_49M) disable iff (rst)
		core_joystick[1] == dir_expected($past(mkeys, 2), $past(joy1), 1))
		else log_mismatch("core_joystick[1]");
	a_btn0: assert property (@(posedge CLK_49M) disable iff (rst)
		core_buttons[0] == btn_expected($past(mkeys, 2), $past(joy0), 0))
		else log_mismatch("core_buttons[0]");
	a_btn1: assert property (@(posedge CLK_49M) disable iff (rst)
		core_buttons[1] == btn_expected($past(mkeys, 2), $past(joy1), 1))
		else log_mismatch("core_buttons[1]");
	a_start: assert property (@(posedge CLK_49M) disable iff (rst)
		core_start == ~{
			$past(mkeys[scancode_pkg::KEY_START2], 2) | $past(joy1[scancode_pkg::JOY_START]),
			$past(mkeys[scancode_pkg::KEY_START1], 2) | $past(joy0[scancode_pkg::JOY_START])})
		else log_mismatch("core_start");
	a_coins: assert property (@(posedge CLK_49M) disable iff (rst)
		core_coins == ~{$past(mkeys[scancode_pkg::KEY_COIN2], 2),
			$past(mkeys[scancode_pkg::KEY_COIN1], 2)
			| $past(joy0[scancode_pkg::JOY_COIN]) | $past(joy1[scancode_pkg::JOY_COIN])})
		else log_mismatch("core_coins");
	a_service: assert property (@(posedge CLK_49M) disable iff (rst)
		core_service == ~$past(mkeys[scancode_pkg::KEY_SERVICE], 2))
		else log_mismatch("core_service");
	a_rot0: assert property (@(posedge CLK_49M) disable iff (rst)
		core_rotary[0] == rotary_expected($past(mrot[0]), $past(is_bootleg)))
		else log_mismatch("core_rotary[0]");
	a_rot1: assert property (@(posedge CLK_49M) disable iff (rst)
		core_rotary[1] == rotary_expected($past(mrot[1]), $past(is_bootleg)))
		else log_mismatch("core_rotary[1]");

	task automatic begin_test(input string name);
		test_name = name;
		err_mark  = errors;
	endtask

	task automatic end_test();
		idle(4); // Pipeline drains into the checks
		tests_run++;
		if (errors != err_mark)
			tests_failed++;
		$display("Test %0d %s: %s", tests_run, test_name, (errors == err_mark) ? "passed" : "failed");
	endtask

	task automatic check_step_gap(input int got, input int want);
		if (got != want) begin
			$display("** Error at time %0t: rotary step after %0d cycles, expected %0d",
				$time, got, want);
			errors++;
		end
	endtask

	// ====================
	// Test sequence
	initial begin
		int cycles;
		int pick;
		void'($urandom(32'h83fb482b));
		rst        = 1'b1;
		ps2_key    = '0;
		joy0       = '0;
		joy1       = '0;
		rot_fast   = 1'b0;
		is_bootleg = 2'b00;
		mkeys      = '0;

		begin_test("reset state");
		apply_reset();
		assert (core_coins == 2'b11 && core_service && core_start == 2'b11 && core_joystick == '1
			&& core_buttons == '1 && core_rotary == {2{~cab_pkg::ROT_HOME}})
			else log_mismatch("reset state");
		end_test();

		begin_test("scancodes");
		for (int i = 0; i < NUM_CODES; i++) begin
			send_key(sc_list[i], 1'b1);
			idle(3);
			send_key(sc_list[i], 1'b0);
			idle(3);
		end
		send_key(8'h5A, 1'b1); // Enter is not mapped
		send_key(scancode_pkg::SC_P1_SHOT, 1'b1);
		send_key(8'h5A, 1'b0); // Shot stays held
		idle(3);
		send_key(scancode_pkg::SC_P1_SHOT, 1'b0);
		end_test();

		begin_test("keys and gamepads");
		for (int n = 0; n < 300; n++) begin
			@(negedge CLK_49M);
			joy0 = 16'($urandom);
			joy1 = 16'($urandom);
			if ($urandom_range(1) == 1) begin
				pick = $urandom_range(NUM_CODES - 1);
				send_key(sc_list[pick], 1'($urandom_range(1)));
			end
		end
		@(negedge CLK_49M);
		joy0 = '0;
		joy1 = '0;
		joy1[scancode_pkg::JOY_COIN] = 1'b1; // Player 2 pad coin lands on coin1
		for (int i = 0; i < NUM_CODES; i++)
			send_key(sc_list[i], 1'b0);
		joy1 = '0;
		joy0[scancode_pkg::JOY_COIN] = 1'b1;
		send_key(scancode_pkg::SC_COIN2, 1'b1);
		idle(3);
		joy0 = '0;
		send_key(scancode_pkg::SC_COIN2, 1'b0);
		end_test();

		begin_test("rotary steps");
		joy0[scancode_pkg::JOY_ROT_L] = 1'b1;
		joy1[scancode_pkg::JOY_ROT_R] = 1'b1;
		wait_rot_change(0, 2 * DIV, cycles); // Align to a tick
		for (int s = 0; s < 9; s++) begin    // Full lap through the wrap
			wait_rot_change(0, 2 * DIV, cycles);
			check_step_gap(cycles, DIV);
		end
		rot_fast = 1'b1;
		wait_rot_change(0, 2 * DIV, cycles);
		for (int s = 0; s < 3; s++) begin
			wait_rot_change(0, 2 * DIV, cycles);
			check_step_gap(cycles, DIV / 2);
		end
		joy0[scancode_pkg::JOY_ROT_R] = 1'b1; // Both held so left applies
		wait_rot_change(0, 2 * DIV, cycles);
		wait_rot_change(0, 2 * DIV, cycles);
		rot_fast = 1'b0;
		end_test();

		begin_test("bootleg rotary");
		is_bootleg = cab_pkg::BOOTLEG_CODE;
		idle(2 * DIV); // Two tick periods with both pads turning
		assert (core_rotary == '0) else log_mismatch("bootleg core_rotary");
		is_bootleg = 2'b00;
		wait_rot_change(0, 2 * DIV, cycles);
		is_bootleg = 2'b10;
		wait_rot_change(0, 2 * DIV, cycles);
		is_bootleg = 2'b11;
		wait_rot_change(1, 2 * DIV, cycles);
		joy0       = '0;
		joy1       = '0;
		is_bootleg = cab_pkg::BOOTLEG_CODE;
		apply_reset();
		assert (core_rotary == '0) else log_mismatch("bootleg reset core_rotary");
		idle(4);
		is_bootleg = 2'b00;
		end_test();

		$display("Tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule
